//--- hdl/ex_pkg.sv
package ex_pkg;

	localparam int WORD_W     = 32;
	localparam int DWORD_W    = 64;   // products, hi/lo, quotient/remainder
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;
	localparam int DIV_STEPS  = 32;   // one quotient bit per step
	localparam int CNT_W      = 6;

	// controller states
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_MACC    = 2'd1;
	localparam logic [1:0] ST_DIV_RUN = 2'd2;
	localparam logic [1:0] ST_DIV_FIX = 2'd3;

	typedef enum logic [4:0] {
		OP_NOP = 5'd0,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_SLL, OP_SRL, OP_SRA,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO,
		OP_MUL, OP_MULT, OP_MULTU,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_DIV, OP_DIVU,
		OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
	} aluop_t;

	// 64-bit hi/lo value, seen whole or as two words
	typedef union packed {
		logic [DWORD_W-1:0] full;
		struct packed {
			logic [WORD_W-1:0] hi;
			logic [WORD_W-1:0] lo;
		} half;
	} hilo_u;

endpackage

//--- hdl/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            valid_i,
	input  ex_pkg::aluop_t  op_i,
	input  logic            last_i,
	output logic            stall_o,
	output logic            commit_o,
	output logic            macc_load_o,
	output logic            div_load_o,
	output logic            div_step_o,
	output logic            div_fix_o,
	output logic            done_o
);
	import ex_pkg::*;

	logic [1:0] state_q;
	logic [1:0] state_d;
	logic       fix_done_q;   // sign fix-up already applied
	logic       is_macc;
	logic       is_div;

	assign is_macc = (op_i == OP_MADD) || (op_i == OP_MADDU) ||
	                 (op_i == OP_MSUB) || (op_i == OP_MSUBU);
	assign is_div  = (op_i == OP_DIV) || (op_i == OP_DIVU);

	always_comb begin
		state_d     = state_q;
		stall_o     = 1'b0;
		commit_o    = 1'b0;
		macc_load_o = 1'b0;
		div_load_o  = 1'b0;
		div_step_o  = 1'b0;
		div_fix_o   = 1'b0;
		case (state_q)
			ST_IDLE: begin
				if (valid_i) begin
					if (is_macc) begin
						stall_o     = 1'b1;
						macc_load_o = 1'b1;   // first step: product into step1
						state_d     = ST_MACC;
					end else if (is_div) begin
						stall_o    = 1'b1;
						div_load_o = 1'b1;
						state_d    = ST_DIV_RUN;
					end else begin
						commit_o = 1'b1;
					end
				end
			end
			ST_MACC: begin
				commit_o = 1'b1;   // second step adds into hi/lo
				state_d  = ST_IDLE;
			end
			ST_DIV_RUN: begin
				stall_o    = 1'b1;
				div_step_o = 1'b1;
				if (last_i) begin
					state_d = ST_DIV_FIX;
				end
			end
			default: begin
				// fix-up cycle, then the commit cycle
				if (fix_done_q) begin
					commit_o = 1'b1;
					state_d  = ST_IDLE;
				end else begin
					stall_o   = 1'b1;
					div_fix_o = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q    <= ST_IDLE;
			fix_done_q <= 1'b0;
			done_o     <= 1'b0;
		end else begin
			state_q    <= state_d;
			fix_done_q <= div_fix_o;
			done_o     <= commit_o;   // one cycle after the commit edge
		end
	end

endmodule

//--- hdl/div_counter.sv
`timescale 1ns/1ps

module div_counter #(
	parameter int STEPS = 32,
	parameter int CNT_W = 6
) (
	input  logic clk,
	input  logic rst_i,
	input  logic load_i,
	input  logic step_i,
	output logic last_o
);

	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= CNT_W'(STEPS);
		end else if (step_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// one step left
	assign last_o = (cnt_q == CNT_W'(1));

endmodule

//--- hdl/alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input  ex_pkg::aluop_t              op_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg1_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg2_i,
	input  logic [ex_pkg::WORD_W-1:0]   hi_i,
	input  logic [ex_pkg::WORD_W-1:0]   lo_i,
	input  logic [ex_pkg::WORD_W-1:0]   prod_lo_i,
	output logic [ex_pkg::WORD_W-1:0]   result_o,
	output logic                        ov_o
);
	import ex_pkg::*;

	logic [WORD_W-1:0]  reg2_mux;
	logic [WORD_W-1:0]  sum;
	logic               ov_sum;
	logic               lt_signed;
	logic               do_sub;
	logic [SHAMT_W-1:0] shamt;

	// count of leading zero bits, WORD_W when v is zero
	function automatic logic [WORD_W-1:0] lead_zeros(input logic [WORD_W-1:0] v);
		logic [WORD_W-1:0] n;
		logic              found;
		n     = WORD_W'(WORD_W);
		found = 1'b0;
		for (int i = WORD_W - 1; i >= 0; i--) begin
			if (!found && v[i]) begin
				n     = WORD_W'(WORD_W - 1 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// sub and slt go through the adder with reg2 negated
	assign do_sub   = (op_i == OP_SUB) || (op_i == OP_SUBU) || (op_i == OP_SLT);
	assign reg2_mux = do_sub ? (~reg2_i + 1'b1) : reg2_i;
	assign sum      = reg1_i + reg2_mux;
	assign shamt    = reg1_i[SHAMT_W-1:0];

	// pos + pos = neg, or neg + neg = pos
	assign ov_sum = (!reg1_i[WORD_W-1] && !reg2_mux[WORD_W-1] && sum[WORD_W-1]) ||
	                (reg1_i[WORD_W-1] && reg2_mux[WORD_W-1] && !sum[WORD_W-1]);

	// neg vs pos, or same sign with a negative difference
	assign lt_signed = (reg1_i[WORD_W-1] && !reg2_i[WORD_W-1]) ||
	                   ((reg1_i[WORD_W-1] == reg2_i[WORD_W-1]) && sum[WORD_W-1]);

	assign ov_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) && ov_sum;

	always_comb begin
		case (op_i)
			OP_AND:  result_o = reg1_i & reg2_i;
			OP_OR:   result_o = reg1_i | reg2_i;
			OP_XOR:  result_o = reg1_i ^ reg2_i;
			OP_NOR:  result_o = ~(reg1_i | reg2_i);
			OP_SLL:  result_o = reg2_i << shamt;
			OP_SRL:  result_o = reg2_i >> shamt;
			OP_SRA:  result_o = $signed(reg2_i) >>> shamt;
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
				result_o = sum;
			end
			OP_SLT:  result_o = WORD_W'(lt_signed);
			OP_SLTU: result_o = WORD_W'(reg1_i < reg2_i);
			OP_CLZ:  result_o = lead_zeros(reg1_i);
			OP_CLO:  result_o = lead_zeros(~reg1_i);   // leading ones = zeros of the inverse
			OP_MUL:  result_o = prod_lo_i;
			OP_MFHI: result_o = hi_i;
			OP_MFLO: result_o = lo_i;
			default: result_o = '0;
		endcase
	end

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
	input  logic                        clk,
	input  logic                        rst_i,
	input  ex_pkg::aluop_t              op_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg1_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg2_i,
	input  logic                        macc_load_i,
	output ex_pkg::hilo_u               prod_o,
	output ex_pkg::hilo_u               step1_o
);
	import ex_pkg::*;

	logic                signed_op;
	logic                sub_op;
	logic [WORD_W-1:0]   mag1;
	logic [WORD_W-1:0]   mag2;
	logic [DWORD_W-1:0]  mag_prod;

	assign signed_op = (op_i == OP_MUL) || (op_i == OP_MULT) ||
	                   (op_i == OP_MADD) || (op_i == OP_MSUB);
	assign sub_op    = (op_i == OP_MSUB) || (op_i == OP_MSUBU);

	// multiply magnitudes, sign restored afterwards
	assign mag1     = (signed_op && reg1_i[WORD_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
	assign mag2     = (signed_op && reg2_i[WORD_W-1]) ? (~reg2_i + 1'b1) : reg2_i;
	assign mag_prod = DWORD_W'(mag1) * DWORD_W'(mag2);

	assign prod_o.full = (signed_op && (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1])) ?
	                     (~mag_prod + 1'b1) : mag_prod;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			step1_o.full <= '0;
		end else if (macc_load_i) begin
			step1_o.full <= sub_op ? (~prod_o.full + 1'b1) : prod_o.full;   // msub adds -prod
		end
	end

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit (
	input  logic                        clk,
	input  logic                        rst_i,
	input  ex_pkg::aluop_t              op_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg1_i,
	input  logic [ex_pkg::WORD_W-1:0]   reg2_i,
	input  logic                        load_i,
	input  logic                        step_i,
	input  logic                        fix_i,
	output ex_pkg::hilo_u               result_o
);
	import ex_pkg::*;

	logic [WORD_W-1:0] quo_q;     // dividend shifts out, quotient shifts in
	logic [WORD_W-1:0] rem_q;
	logic [WORD_W-1:0] dvs_q;
	logic              neg_q_q;
	logic              neg_r_q;
	logic              signed_op;
	logic [WORD_W:0]   partial;
	logic [WORD_W+1:0] diff;

	assign signed_op = (op_i == OP_DIV);
	assign partial   = {rem_q, quo_q[WORD_W-1]};
	assign diff      = {1'b0, partial} - {2'b00, dvs_q};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			quo_q    <= '0;
			rem_q    <= '0;
			dvs_q    <= '0;
			neg_q_q  <= 1'b0;
			neg_r_q  <= 1'b0;
			result_o <= '0;
		end else if (load_i) begin
			quo_q   <= (signed_op && reg1_i[WORD_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
			dvs_q   <= (signed_op && reg2_i[WORD_W-1]) ? (~reg2_i + 1'b1) : reg2_i;
			rem_q   <= '0;
			neg_q_q <= signed_op && (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1]);
			neg_r_q <= signed_op && reg1_i[WORD_W-1];   // remainder follows dividend
		end else if (step_i) begin
			if (!diff[WORD_W+1]) begin   // no borrow, keep the difference
				rem_q <= diff[WORD_W-1:0];
				quo_q <= {quo_q[WORD_W-2:0], 1'b1};
			end else begin
				rem_q <= partial[WORD_W-1:0];
				quo_q <= {quo_q[WORD_W-2:0], 1'b0};
			end
		end else if (fix_i) begin
			result_o.half.lo <= neg_q_q ? (~quo_q + 1'b1) : quo_q;
			result_o.half.hi <= neg_r_q ? (~rem_q + 1'b1) : rem_q;
		end
	end

endmodule

//--- hdl/hilo_wb.sv
`timescale 1ns/1ps

module hilo_wb (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          commit_i,
	input  ex_pkg::aluop_t                op_i,
	input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
	input  logic [ex_pkg::WORD_W-1:0]     alu_result_i,
	input  logic                          alu_ov_i,
	input  ex_pkg::hilo_u                 prod_i,
	input  ex_pkg::hilo_u                 step1_i,
	input  ex_pkg::hilo_u                 div_i,
	input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                          wreg_i,
	output logic [ex_pkg::WORD_W-1:0]     hi_o,
	output logic [ex_pkg::WORD_W-1:0]     lo_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                          wreg_o,
	output logic [ex_pkg::WORD_W-1:0]     wdata_o,
	output logic                          ov_o
);
	import ex_pkg::*;

	hilo_u hilo_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			hilo_q  <= '0;
			wdata_o <= '0;
			wreg_o  <= 1'b0;
			ov_o    <= 1'b0;
		end else if (commit_i) begin
			case (op_i)
				OP_MULT, OP_MULTU: hilo_q.full <= prod_i.full;
				OP_MTHI:           hilo_q.half.hi <= reg1_i;
				OP_MTLO:           hilo_q.half.lo <= reg1_i;
				OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
					hilo_q.full <= step1_i.full + hilo_q.full;   // second step
				end
				OP_DIV, OP_DIVU:   hilo_q.full <= div_i.full;
				default:           hilo_q <= hilo_q;
			endcase
			wdata_o <= alu_result_i;
			wreg_o  <= wreg_i && !alu_ov_i;   // overflow drops the write
			ov_o    <= alu_ov_i;
		end
	end

	always_ff @(posedge clk) begin
		if (commit_i) begin
			wd_o <= wd_i;
		end
	end

	assign hi_o = hilo_q.half.hi;
	assign lo_o = hilo_q.half.lo;

endmodule

//--- hdl/ex_top.sv
`timescale 1ns/1ps

module ex_top (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          valid_i,
	input  ex_pkg::aluop_t                op_i,
	input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
	input  logic [ex_pkg::WORD_W-1:0]     reg2_i,
	input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
	input  logic                          wreg_i,
	output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
	output logic                          wreg_o,
	output logic [ex_pkg::WORD_W-1:0]     wdata_o,
	output logic                          ov_o,
	output logic                          stall_o,
	output logic                          done_o
);
	import ex_pkg::*;

	logic              commit;
	logic              macc_load;
	logic              div_load;
	logic              div_step;
	logic              div_fix;
	logic              last;
	logic [WORD_W-1:0] alu_result;
	logic              alu_ov;
	logic [WORD_W-1:0] hi;
	logic [WORD_W-1:0] lo;
	hilo_u             prod;
	hilo_u             step1;
	hilo_u             div_res;

	ex_ctrl u_ctrl (
		.clk(clk), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i), .last_i(last),
		.stall_o(stall_o), .commit_o(commit), .macc_load_o(macc_load),
		.div_load_o(div_load), .div_step_o(div_step), .div_fix_o(div_fix),
		.done_o(done_o)
	);

	div_counter #(.STEPS(DIV_STEPS), .CNT_W(CNT_W)) u_cnt (
		.clk(clk), .rst_i(rst_i), .load_i(div_load), .step_i(div_step), .last_o(last)
	);

	alu_core u_alu (
		.op_i(op_i), .reg1_i(reg1_i), .reg2_i(reg2_i), .hi_i(hi), .lo_i(lo),
		.prod_lo_i(prod.half.lo), .result_o(alu_result), .ov_o(alu_ov)
	);

	mul_unit u_mul (
		.clk(clk), .rst_i(rst_i), .op_i(op_i), .reg1_i(reg1_i), .reg2_i(reg2_i),
		.macc_load_i(macc_load), .prod_o(prod), .step1_o(step1)
	);

	div_unit u_div (
		.clk(clk), .rst_i(rst_i), .op_i(op_i), .reg1_i(reg1_i), .reg2_i(reg2_i),
		.load_i(div_load), .step_i(div_step), .fix_i(div_fix), .result_o(div_res)
	);

	hilo_wb u_wb (
		.clk(clk), .rst_i(rst_i), .commit_i(commit), .op_i(op_i), .reg1_i(reg1_i),
		.alu_result_i(alu_result), .alu_ov_i(alu_ov), .prod_i(prod), .step1_i(step1),
		.div_i(div_res), .wd_i(wd_i), .wreg_i(wreg_i), .hi_o(hi), .lo_o(lo),
		.wd_o(wd_o), .wreg_o(wreg_o), .wdata_o(wdata_o), .ov_o(ov_o)
	);

endmodule

//--- tests/tb_ex.sv
`timescale 1ns/1ps

module tb_ex;
	import ex_pkg::*;

	logic                  clk;
	logic                  rst_i;
	logic                  valid_i;
	aluop_t                op_i;
	logic [WORD_W-1:0]     reg1_i;
	logic [WORD_W-1:0]     reg2_i;
	logic [REG_ADDR_W-1:0] wd_i;
	logic                  wreg_i;
	logic [REG_ADDR_W-1:0] wd_o;
	logic                  wreg_o;
	logic [WORD_W-1:0]     wdata_o;
	logic                  ov_o;
	logic                  stall_o;
	logic                  done_o;

	logic [31:0] model_hi;   // reference copy of hi/lo
	logic [31:0] model_lo;
	logic [31:0] a;
	logic [31:0] b;
	aluop_t      cur_op;
	int          seed;
	int          errors;
	int          checks;
	int          test_base;

	ex_top UUT (
		.clk(clk), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i), .reg1_i(reg1_i),
		.reg2_i(reg2_i), .wd_i(wd_i), .wreg_i(wreg_i), .wd_o(wd_o), .wreg_o(wreg_o),
		.wdata_o(wdata_o), .ov_o(ov_o), .stall_o(stall_o), .done_o(done_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// length of the run of bit b from the msb down
	function automatic logic [31:0] lead_count(input logic [31:0] v, input logic b);
		int n;
		n = 0;
		while (n < 32 && v[31] == b) begin
			v = v << 1;
			n++;
		end
		return 32'(n);
	endfunction

	function automatic logic [31:0] model_word(input aluop_t op, input logic [31:0] ra,
	                                           input logic [31:0] rb);
		logic [63:0] p;
		case (op)
			OP_AND:          return ra & rb;
			OP_OR:           return ra | rb;
			OP_XOR:          return ra ^ rb;
			OP_NOR:          return ~(ra | rb);
			OP_SLL:          return rb << ra[4:0];
			OP_SRL:          return rb >> ra[4:0];
			OP_SRA:          return $signed(rb) >>> ra[4:0];
			OP_ADD, OP_ADDU: return ra + rb;
			OP_SUB, OP_SUBU: return ra - rb;
			OP_SLT:          return ($signed(ra) < $signed(rb)) ? 32'd1 : 32'd0;
			OP_SLTU:         return (ra < rb) ? 32'd1 : 32'd0;
			OP_CLZ:          return lead_count(ra, 1'b0);
			OP_CLO:          return lead_count(ra, 1'b1);
			OP_MUL: begin
				p = longint'($signed(ra)) * longint'($signed(rb));
				return p[31:0];   // low word only
			end
			OP_MFHI:         return model_hi;
			OP_MFLO:         return model_lo;
			default:         return 32'd0;
		endcase
	endfunction

	// signed overflow when the exact sum leaves the 32-bit range
	function automatic logic model_ov(input aluop_t op, input logic [31:0] ra,
	                                  input logic [31:0] rb);
		longint s;
		if (op == OP_ADD) begin
			s = longint'($signed(ra)) + longint'($signed(rb));
		end else if (op == OP_SUB) begin
			s = longint'($signed(ra)) - longint'($signed(rb));
		end else begin
			return 1'b0;
		end
		return s != longint'($signed(s[31:0]));
	endfunction

	// {remainder, quotient}
	function automatic logic [63:0] div_model(input logic sgn, input logic [31:0] ra,
	                                          input logic [31:0] rb);
		int sa;
		int sb;
		sa = ra;
		sb = rb;
		if (rb == 32'd0) begin
			// all-ones quotient, negated for a negative dividend
			if (sgn && ra[31]) begin
				return {ra, 32'd1};
			end
			return {ra, 32'hffffffff};
		end
		if (sgn) begin
			return {32'(sa % sb), 32'(sa / sb)};
		end
		return {ra % rb, ra / rb};
	endfunction

	function automatic logic [63:0] model_hilo(input aluop_t op, input logic [31:0] ra,
	                                           input logic [31:0] rb);
		logic [63:0] acc;
		logic [63:0] p;
		acc = {model_hi, model_lo};
		if (op inside {OP_MULT, OP_MADD, OP_MSUB}) begin
			p = longint'($signed(ra)) * longint'($signed(rb));
		end else begin
			p = {32'd0, ra} * {32'd0, rb};
		end
		case (op)
			OP_MULT, OP_MULTU: acc = p;
			OP_MADD, OP_MADDU: acc = acc + p;
			OP_MSUB, OP_MSUBU: acc = acc - p;
			OP_MTHI:           acc[63:32] = ra;
			OP_MTLO:           acc[31:0] = ra;
			OP_DIV:            acc = div_model(1'b1, ra, rb);
			OP_DIVU:           acc = div_model(1'b0, ra, rb);
			default:           acc = acc;
		endcase
		return acc;
	endfunction

	task automatic expect_word(input string what, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic exec(input aluop_t op, input logic [31:0] ra, input logic [31:0] rb);
		logic [31:0]           exp_word;
		logic                  exp_ov;
		logic                  multi;
		logic                  has_word;
		logic                  stalled;
		logic                  accepted;
		logic                  wr;
		logic [REG_ADDR_W-1:0] wd;
		int                    n;
		exp_word = model_word(op, ra, rb);
		exp_ov   = model_ov(op, ra, rb);
		multi    = op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_DIV, OP_DIVU};
		has_word = !(multi || (op inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO}));
		wd       = REG_ADDR_W'($random(seed));
		// write enable random except where overflow can clear it
		wr       = (op inside {OP_ADD, OP_SUB}) ? 1'b1 : 1'($random(seed));
		stalled  = 1'b0;
		accepted = 1'b0;
		n        = 0;
		@(negedge clk);
		op_i    = op;
		reg1_i  = ra;
		reg2_i  = rb;
		wd_i    = wd;
		wreg_i  = wr;
		valid_i = 1'b1;
		// hold until a cycle without stall, that edge commits
		while (!accepted && n < 64) begin
			#5;   // mid cycle, stall_o settled
			if (stall_o) begin
				stalled = 1'b1;
			end else begin
				accepted = 1'b1;
			end
			@(negedge clk);
			n++;
		end
		valid_i = 1'b0;
		{model_hi, model_lo} = model_hilo(op, ra, rb);
		n = 0;
		while (!done_o && n < 4) begin
			@(negedge clk);
			n++;
		end
		if (!accepted || !done_o) begin
			errors++;
			$display("timeout at %0d ns: %s was never completed", $time, op.name());
		end else begin
			if (has_word) begin
				expect_word($sformatf("%s wdata_o", op.name()), wdata_o, exp_word);
			end
			expect_word($sformatf("%s ov_o", op.name()), 32'(ov_o), 32'(exp_ov));
			expect_word($sformatf("%s wreg_o", op.name()), 32'(wreg_o),
			            32'(wr && !exp_ov));
			expect_word($sformatf("%s wd_o", op.name()), 32'(wd_o), 32'(wd));
			expect_word($sformatf("%s stall seen", op.name()), 32'(stalled), 32'(multi));
			@(negedge clk);
			expect_word($sformatf("%s done_o width", op.name()), 32'(done_o), 32'd0);
		end
	endtask

	task automatic read_hilo();
		exec(OP_MFHI, 32'd0, 32'd0);
		exec(OP_MFLO, 32'd0, 32'd0);
	endtask

	task automatic end_test(input string name);
		$display("test %-9s %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		seed      = 76;
		errors    = 0;
		checks    = 0;
		test_base = 0;
		model_hi  = '0;
		model_lo  = '0;
		rst_i     = 1'b1;
		valid_i   = 1'b0;
		op_i      = OP_NOP;
		reg1_i    = '0;
		reg2_i    = '0;
		wd_i      = '0;
		wreg_i    = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		expect_word("done_o after reset", 32'(done_o), 32'd0);
		expect_word("stall_o after reset", 32'(stall_o), 32'd0);
		expect_word("wreg_o after reset", 32'(wreg_o), 32'd0);
		expect_word("ov_o after reset", 32'(ov_o), 32'd0);
		expect_word("wdata_o after reset", wdata_o, 32'd0);
		read_hilo();   // both zero
		end_test("reset");

		for (cur_op = OP_AND; cur_op <= OP_SRA; cur_op = cur_op.next()) begin
			for (int j = 0; j < 4; j++) begin
				exec(cur_op, $random(seed), $random(seed));
			end
		end
		end_test("logic");

		for (cur_op = OP_ADD; cur_op <= OP_CLO; cur_op = cur_op.next()) begin
			for (int j = 0; j < 4; j++) begin
				a = $random(seed) >> (j * 8);   // longer leading runs for clz/clo
				b = $random(seed);
				if (cur_op == OP_CLO) begin
					a = ~a;
				end
				exec(cur_op, a, b);
			end
		end
		exec(OP_ADD, 32'h7fffffff, 32'd1);   // forced overflow
		exec(OP_SUB, 32'h80000000, 32'd1);
		exec(OP_ADDU, 32'h7fffffff, 32'd1);
		exec(OP_CLZ, 32'd0, 32'd0);
		exec(OP_CLO, 32'hffffffff, 32'd0);
		end_test("arith");

		for (int j = 0; j < 4; j++) begin
			exec(OP_MUL, $random(seed), $random(seed));
			exec(OP_MULT, $random(seed), $random(seed));
			read_hilo();
			exec(OP_MULTU, $random(seed) | 32'h80000000, $random(seed));
			read_hilo();
		end
		exec(OP_MTHI, $random(seed), 32'd0);
		read_hilo();
		exec(OP_MTLO, $random(seed), 32'd0);
		read_hilo();
		end_test("mul_hilo");

		for (cur_op = OP_MADD; cur_op <= OP_MSUBU; cur_op = cur_op.next()) begin
			exec(OP_MTHI, $random(seed), 32'd0);
			exec(OP_MTLO, $random(seed), 32'd0);
			exec(cur_op, $random(seed), $random(seed));
			read_hilo();
		end
		end_test("macc");

		for (int j = 0; j < 6; j++) begin
			a = $random(seed);
			b = $random(seed) >> (j * 4);   // smaller divisors, longer quotients
			if ((j % 2) == 1) begin
				b = -b;
			end
			exec(OP_DIV, a, b);
			read_hilo();
			exec(OP_DIVU, a, b);
			read_hilo();
		end
		exec(OP_DIV, 32'hfffff123, 32'd0);
		read_hilo();
		exec(OP_DIV, 32'h00012345, 32'd0);
		read_hilo();
		exec(OP_DIVU, 32'h89abcdef, 32'd0);
		read_hilo();
		end_test("divide");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
hdl/ex_pkg.sv
hdl/ex_ctrl.sv
hdl/div_counter.sv
hdl/alu_core.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/hilo_wb.sv
hdl/ex_top.sv
tests/tb_ex.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_ex -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_ex)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
